// File: design/conv_decode.sv
/* conv decode stage
   accepts a four-phase request, latches the payload and classifies the opcode */

`timescale 1ns/1ps

module conv_decode (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  req_i,
    input  conv_pkg::conv_req_t   req_data_i,
    input  logic                  release_i,
    output logic                  start_o,
    output logic                  reject_o,
    output conv_pkg::conv_job_t   job_o
);

    import conv_pkg::*;

    hs_state_e state_q;

    // pulse goes out one edge after capture
    logic pend_q;
    logic illegal_q;

    // opcode classification of the incoming request
    logic op_legal;
    logic op_bias;

    always_comb begin
        op_legal = 1'b0;
        op_bias  = 1'b0;
        case (req_data_i.op)
            OP_CONV_BIAS: begin
                op_legal = 1'b1;
                op_bias  = 1'b1;
            end
            OP_CONV_NOBIAS: begin
                op_legal = 1'b1;
            end
            default: begin
                // codes 2 and 3 fall through as illegal
                op_legal = 1'b0;
            end
        endcase
    end

    // ======================================================================
    // handshake control
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= HS_IDLE;
            pend_q    <= 1'b0;
            illegal_q <= 1'b0;
            start_o   <= 1'b0;
            reject_o  <= 1'b0;
        end else begin
            // one-cycle pulses cleared by default
            start_o  <= pend_q & ~illegal_q;
            reject_o <= pend_q & illegal_q;
            pend_q   <= 1'b0;
            case (state_q)
                HS_IDLE: begin
                    if (req_i) begin
                        pend_q    <= 1'b1;
                        illegal_q <= ~op_legal;
                        state_q   <= HS_BUSY;
                    end
                end
                HS_BUSY: begin
                    // held request stays blocked until the result side lets go
                    if (release_i) begin
                        state_q <= HS_IDLE;
                    end
                end
                default: begin
                    state_q <= HS_IDLE;
                end
            endcase
        end
    end

    // payload held for the whole job
    always_ff @(posedge clk_i) begin
        if (state_q == HS_IDLE && req_i) begin
            job_o.use_bias <= op_bias;
            job_o.window   <= req_data_i.window;
            job_o.kernel   <= req_data_i.kernel;
            job_o.bias     <= req_data_i.bias;
        end
    end

    // result side only releases a job that is held here
    a_release_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        release_i |-> (state_q == HS_BUSY));

endmodule

// File: design/conv_engine_top.sv
/* conv engine top level
   decode, sequencer, node and result stage behind a four-phase handshake */

`timescale 1ns/1ps

module conv_engine_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  req_i,
    input  conv_pkg::conv_req_t   req_data_i,
    output logic                  ack_o,
    output conv_pkg::conv_resp_t  resp_o
);

    import conv_pkg::*;

    // decode to sequencer and result
    logic      start;
    logic      reject;
    conv_job_t job;

    // sequencer to node
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    word_t            kernel_word;
    logic             clr;
    logic             bias_en;
    logic             add_en;
    logic             done_en;

    // node and sequencer to result
    logic  node_valid;
    word_t node_data;
    logic  release_req;

    conv_decode decode0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .release_i  (release_req),
        .start_o    (start),
        .reject_o   (reject),
        .job_o      (job)
    );

    conv_sequencer seq0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .start_i      (start),
        .job_i        (job),
        .row_o        (row),
        .col_o        (col),
        .kernel_o     (kernel_word),
        .clr_o        (clr),
        .bias_en_o    (bias_en),
        .add_en_o     (add_en),
        .done_en_o    (done_en),
        .node_valid_o (node_valid)
    );

    // window and bias come straight from the held job
    conv_node node0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .data_i    (job.window),
        .kernel_i  (kernel_word),
        .bias_i    (job.bias),
        .row_i     (row),
        .col_i     (col),
        .clr_i     (clr),
        .bias_en_i (bias_en),
        .add_en_i  (add_en),
        .done_en_i (done_en),
        .data_o    (node_data)
    );

    conv_result result0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .node_valid_i (node_valid),
        .node_data_i  (node_data),
        .reject_i     (reject),
        .req_i        (req_i),
        .resp_o       (resp_o),
        .ack_o        (ack_o),
        .release_o    (release_req)
    );

endmodule

// File: design/conv_node.sv
/* convolution node
   multiply-accumulate over the window with a ReLU output register */

`timescale 1ns/1ps

module conv_node (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  conv_pkg::window_t             data_i,
    input  conv_pkg::word_t               kernel_i,
    input  conv_pkg::word_t               bias_i,
    input  logic [conv_pkg::ROW_W-1:0]    row_i,
    input  logic [conv_pkg::COL_W-1:0]    col_i,
    input  logic                          clr_i,
    input  logic                          bias_en_i,
    input  logic                          add_en_i,
    input  logic                          done_en_i,
    output conv_pkg::word_t               data_o
);

    import conv_pkg::*;

    // selected pixel and full-width product
    word_t                         pixel;
    logic signed [2*WORD_SIZE-1:0] product;

    // running sum, wraps modulo 2^16
    word_t addend;
    word_t sum_n;
    word_t sum_q;

    assign pixel   = data_i[row_i][col_i];
    assign product = kernel_i * pixel;

    // low product word or the bias
    assign addend = add_en_i ? word_t'(product[WORD_SIZE-1:0]) : bias_i;
    assign sum_n  = sum_q + addend;

    // accumulator, clr wins over any add
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sum_q <= '0;
        end else if (clr_i) begin
            sum_q <= '0;
        end else if (add_en_i || bias_en_i) begin
            sum_q <= sum_n;
        end
    end

    // ReLU on the finished sum
    // signed compare, zero passes as zero
    always_ff @(posedge clk_i) begin
        if (done_en_i) begin
            if (sum_q > word_t'(0)) begin
                data_o <= sum_q;
            end else begin
                data_o <= '0;
            end
        end
    end

endmodule

// File: design/conv_pkg.sv
/* conv engine shared definitions
   word sizes, opcode and state encodings, request/job/response structs */

package conv_pkg;

    // ======================================================================
    // sizes
    // ======================================================================

    localparam int WORD_SIZE     = 16;
    localparam int KERNEL_HEIGHT = 3;
    localparam int KERNEL_WIDTH  = 2;

    // index widths for row and column walk
    localparam int ROW_W = 2;
    localparam int COL_W = 2;

    // ======================================================================
    // data types
    // ======================================================================

    // one signed data word
    typedef logic signed [WORD_SIZE-1:0] word_t;

    // row-major window, shared by pixels and kernel (96 bits)
    typedef word_t [KERNEL_HEIGHT-1:0][KERNEL_WIDTH-1:0] window_t;

    // opcodes; codes 2 and 3 are illegal
    typedef enum logic [1:0] {
        OP_CONV_BIAS   = 2'd0,
        OP_CONV_NOBIAS = 2'd1
    } conv_op_e;

    // request from the requester, 210 bits
    typedef struct packed {
        conv_op_e op;
        window_t  window;
        window_t  kernel;
        word_t    bias;
    } conv_req_t;

    // decoded job for the sequencer, 209 bits
    typedef struct packed {
        logic    use_bias;
        window_t window;
        window_t kernel;
        word_t   bias;
    } conv_job_t;

    // response back to the requester, 17 bits
    typedef struct packed {
        word_t data;
        logic  err;
    } conv_resp_t;

    // ======================================================================
    // state encodings
    // ======================================================================

    // execute stage walk
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_BIAS,
        SEQ_MAC,
        SEQ_DONE,
        SEQ_FLUSH
    } seq_state_e;

    // four-phase handshake tracking, decode and result side
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_BUSY,
        HS_WAIT_REL
    } hs_state_e;

endpackage

// File: design/conv_result.sv
/* conv result stage
   holds the response, raises ack and waits for the requester to release */

`timescale 1ns/1ps

module conv_result (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  node_valid_i,
    input  conv_pkg::word_t       node_data_i,
    input  logic                  reject_i,
    input  logic                  req_i,
    output conv_pkg::conv_resp_t  resp_o,
    output logic                  ack_o,
    output logic                  release_o
);

    import conv_pkg::*;

    hs_state_e state_q;

    // ======================================================================
    // response and ack
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= HS_IDLE;
            resp_o    <= '0;
            ack_o     <= 1'b0;
            release_o <= 1'b0;
        end else begin
            release_o <= 1'b0;
            case (state_q)
                HS_IDLE: begin
                    // request seen, job under way
                    if (req_i) begin
                        state_q <= HS_BUSY;
                    end
                end
                HS_BUSY: begin
                    if (reject_i) begin
                        // illegal opcode, zero data with error
                        resp_o.data <= '0;
                        resp_o.err  <= 1'b1;
                        ack_o       <= 1'b1;
                        state_q     <= HS_WAIT_REL;
                    end else if (node_valid_i) begin
                        resp_o.data <= node_data_i;
                        resp_o.err  <= 1'b0;
                        ack_o       <= 1'b1;
                        state_q     <= HS_WAIT_REL;
                    end
                end
                HS_WAIT_REL: begin
                    // ack held as long as req stays high
                    if (!req_i) begin
                        ack_o     <= 1'b0;
                        release_o <= 1'b1;
                        state_q   <= HS_IDLE;
                    end
                end
                default: begin
                    state_q <= HS_IDLE;
                end
            endcase
        end
    end

    // requester may sample resp at any point while ack is up
    a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_o |=> (!ack_o || $stable(resp_o)));

endmodule

// File: design/conv_sequencer.sv
/* conv execute stage sequencer
   clears the node, adds the bias, then walks all kernel positions row-major */

`timescale 1ns/1ps

module conv_sequencer (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          start_i,
    input  conv_pkg::conv_job_t           job_i,
    output logic [conv_pkg::ROW_W-1:0]    row_o,
    output logic [conv_pkg::COL_W-1:0]    col_o,
    output conv_pkg::word_t               kernel_o,
    output logic                          clr_o,
    output logic                          bias_en_o,
    output logic                          add_en_o,
    output logic                          done_en_o,
    output logic                          node_valid_o
);

    import conv_pkg::*;

    seq_state_e state_q;

    // walk position of the next product
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;
    logic             last_pos;
    logic             last_col;

    assign last_col = (col_q == COL_W'(KERNEL_WIDTH - 1));
    assign last_pos = last_col && (row_q == ROW_W'(KERNEL_HEIGHT - 1));

    // ======================================================================
    // state machine and node enables
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= SEQ_IDLE;
            row_q        <= '0;
            col_q        <= '0;
            row_o        <= '0;
            col_o        <= '0;
            clr_o        <= 1'b0;
            bias_en_o    <= 1'b0;
            add_en_o     <= 1'b0;
            done_en_o    <= 1'b0;
            node_valid_o <= 1'b0;
        end else begin
            // all enables are single-cycle
            clr_o        <= 1'b0;
            bias_en_o    <= 1'b0;
            add_en_o     <= 1'b0;
            done_en_o    <= 1'b0;
            node_valid_o <= 1'b0;
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i) begin
                        // clear cycle goes out while the next state is pending
                        clr_o   <= 1'b1;
                        row_q   <= '0;
                        col_q   <= '0;
                        state_q <= job_i.use_bias ? SEQ_BIAS : SEQ_MAC;
                    end
                end
                SEQ_BIAS: begin
                    bias_en_o <= 1'b1;
                    state_q   <= SEQ_MAC;
                end
                SEQ_MAC: begin
                    add_en_o <= 1'b1;
                    row_o    <= row_q;
                    col_o    <= col_q;
                    if (last_pos) begin
                        state_q <= SEQ_DONE;
                    end else if (last_col) begin
                        // wrap to next row
                        col_q <= '0;
                        row_q <= row_q + 1'b1;
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                SEQ_DONE: begin
                    done_en_o <= 1'b1;
                    state_q   <= SEQ_FLUSH;
                end
                SEQ_FLUSH: begin
                    // node output register is loaded by now
                    node_valid_o <= 1'b1;
                    state_q      <= SEQ_IDLE;
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    // kernel word matching the presented position
    always_ff @(posedge clk_i) begin
        if (state_q == SEQ_MAC) begin
            kernel_o <= job_i.kernel[row_q][col_q];
        end
    end

    // node adds one term per cycle
    a_one_term: assert property (@(posedge clk_i) disable iff (reset_i)
        !(bias_en_o && add_en_o));

endmodule

// File: files.f
design/conv_pkg.sv
design/conv_decode.sv
design/conv_sequencer.sv
design/conv_node.sv
design/conv_result.sv
design/conv_engine_top.sv
verif/conv_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the conv engine testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
SIM=conv_engine_sim

verilator --binary --timing --assert -sv \
    -f files.f \
    --top-module conv_engine_tb \
    -Mdir "$OBJ" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "run_sim: build failed"
    exit 1
fi

"./$OBJ/$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulator exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "run_sim: failure reported in $LOG"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "run_sim: no result line in $LOG"
    exit 1
fi
exit 0

// File: verif/conv_engine_tb.sv
/* conv engine testbench
   fixed and random request table driven through the four-phase handshake */

`timescale 1ns/1ps

module conv_engine_tb;

    import conv_pkg::*;

    localparam int NUM_FIXED   = 11;
    localparam int NUM_RANDOM  = 20;
    localparam int NUM_TESTS   = NUM_FIXED + NUM_RANDOM;
    localparam int ACK_TIMEOUT = 64;

    // one stimulus row with its expected response
    typedef struct packed {
        logic [1:0] op;
        window_t    window;
        window_t    kernel;
        word_t      bias;
        logic [3:0] hold;
        conv_resp_t expected;
    } test_row_t;

    logic       clk_i;
    logic       reset_i;
    logic       req_i;
    conv_req_t  req_data_i;
    logic       ack_o;
    conv_resp_t resp_o;

    test_row_t   tests [NUM_TESTS];
    logic [31:0] rng_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        hung;
    logic        test_ok;

    conv_engine_top dut0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .ack_o      (ack_o),
        .resp_o     (resp_o)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    // ====================================================================
    // stimulus and reference model
    // ====================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // row-major fill, [row][col]
    function automatic window_t build_window(input word_t w00, input word_t w01,
                                             input word_t w10, input word_t w11,
                                             input word_t w20, input word_t w21);
        window_t w;
        w[0][0] = w00;
        w[0][1] = w01;
        w[1][0] = w10;
        w[1][1] = w11;
        w[2][0] = w20;
        w[2][1] = w21;
        return w;
    endfunction

    // low product words summed mod 2^16, bias for op 0, then ReLU
    function automatic conv_resp_t model_response(input logic [1:0] op, input window_t win,
                                                  input window_t ker, input word_t bias);
        conv_resp_t         resp;
        word_t              sum;
        logic signed [31:0] prod;
        resp = '0;
        if (op > 2'd1) begin
            // illegal code, no compute
            resp.err = 1'b1;
        end else begin
            sum = (op == 2'd0) ? bias : '0;
            for (int r = 0; r < KERNEL_HEIGHT; r++) begin
                for (int c = 0; c < KERNEL_WIDTH; c++) begin
                    prod = win[r][c] * ker[r][c];
                    sum  = sum + prod[15:0];
                end
            end
            if (sum > 16'sd0) begin
                resp.data = sum;
            end
        end
        return resp;
    endfunction

    task automatic load_row(input int idx, input logic [1:0] op, input window_t win,
                            input window_t ker, input word_t bias, input logic [3:0] hold,
                            input word_t exp_data, input logic exp_err);
        tests[idx].op           = op;
        tests[idx].window       = win;
        tests[idx].kernel       = ker;
        tests[idx].bias         = bias;
        tests[idx].hold         = hold;
        tests[idx].expected.data = exp_data;
        tests[idx].expected.err  = exp_err;
    endtask

    task automatic build_table();
        window_t    ramp;
        window_t    ones;
        window_t    neg_ones;
        window_t    mixed;
        window_t    big;
        window_t    lone;
        window_t    tens;
        window_t    alt;
        window_t    win;
        window_t    ker;
        word_t      bias;
        logic [1:0] op;
        logic [3:0] hold;
        conv_resp_t resp;
        ramp     = build_window(16'sd1, 16'sd2, 16'sd3, 16'sd4, 16'sd5, 16'sd6);
        ones     = build_window(16'sd1, 16'sd1, 16'sd1, 16'sd1, 16'sd1, 16'sd1);
        neg_ones = build_window(-16'sd1, -16'sd1, -16'sd1, -16'sd1, -16'sd1, -16'sd1);
        mixed    = build_window(16'sd2, -16'sd1, 16'sd3, 16'sd0, 16'sd1, -16'sd2);
        big      = build_window(16'h4000, 16'h4000, 16'h4000, 16'h4000, 16'h4000, 16'h4000);
        lone     = build_window(16'sd300, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0);
        tens     = build_window(16'sd10, 16'sd20, 16'sd30, 16'sd40, 16'sd50, 16'sd60);
        alt      = build_window(16'sd1, 16'sd2, 16'sd1, 16'sd2, 16'sd1, 16'sd2);
        // hand-computed rows
        load_row(0, 2'd0, ramp, ones, 16'sd10, 4'd0, 16'sd31, 1'b0);
        load_row(1, 2'd0, ramp, mixed, 16'sd100, 4'd5, 16'sd102, 1'b0);
        load_row(2, 2'd1, ramp, ones, 16'sd30000, 4'd0, 16'sd21, 1'b0);
        load_row(3, 2'd0, ramp, neg_ones, 16'sd5, 4'd0, 16'sd0, 1'b0);
        load_row(4, 2'd0, ramp, ones, -16'sd21, 4'd0, 16'sd0, 1'b0);
        // 6 x 0x4000 lands on 0x8000
        load_row(5, 2'd1, big, ones, 16'sd0, 4'd0, 16'sd0, 1'b0);
        // 90000 keeps its low word, 24464
        load_row(6, 2'd1, lone, lone, 16'sd0, 4'd0, 16'sd24464, 1'b0);
        load_row(7, 2'd2, ramp, ones, 16'sd10, 4'd0, 16'sd0, 1'b1);
        load_row(8, 2'd3, ramp, ones, 16'sd10, 4'd3, 16'sd0, 1'b1);
        load_row(9, 2'd0, tens, alt, -16'sd30, 4'd6, 16'sd300, 1'b0);
        load_row(10, 2'd1, ramp, ones, 16'sd0, 4'd0, 16'sd21, 1'b0);
        // random rows, legal opcodes only
        for (int n = 0; n < NUM_RANDOM; n++) begin
            for (int r = 0; r < KERNEL_HEIGHT; r++) begin
                for (int c = 0; c < KERNEL_WIDTH; c++) begin
                    rng_state = xorshift32(rng_state);
                    win[r][c] = rng_state[15:0];
                    ker[r][c] = rng_state[31:16];
                end
            end
            rng_state = xorshift32(rng_state);
            bias      = rng_state[15:0];
            op        = {1'b0, rng_state[16]};
            hold      = {2'b00, rng_state[18:17]};
            resp      = model_response(op, win, ker, bias);
            load_row(NUM_FIXED + n, op, win, ker, bias, hold, resp.data, resp.err);
        end
    endtask

    // ====================================================================
    // checks and waits
    // ====================================================================

    task automatic check_resp(input conv_resp_t actual, input conv_resp_t expected,
                              input string what);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s, expected data %0d err %b, got data %0d err %b",
                     $time, what, expected.data, expected.err, actual.data, actual.err);
        end
    endtask

    task automatic check_ack_high(input logic actual, input string what);
        if (actual !== 1'b1) begin
            errors++;
            $display("Error at %0t ns: %s, ack_o dropped while req_i held", $time, what);
        end
    endtask

    task automatic check_ack_low(input logic actual, input string what);
        if (actual !== 1'b0) begin
            errors++;
            $display("Error at %0t ns: %s, ack_o still high", $time, what);
        end
    endtask

    task automatic wait_ack_rise(input int idx, output logic ok);
        int cycles;
        cycles = 0;
        while (ack_o !== 1'b1 && cycles < ACK_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        ok = (ack_o === 1'b1);
        if (!ok) begin
            $display("test %0d: timeout, ack_o never rose within %0d cycles", idx, ACK_TIMEOUT);
        end
    endtask

    task automatic wait_ack_fall(input int idx, output logic ok);
        int cycles;
        cycles = 0;
        while (ack_o !== 1'b0 && cycles < ACK_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        ok = (ack_o === 1'b0);
        if (!ok) begin
            $display("test %0d: timeout, ack_o never fell within %0d cycles", idx, ACK_TIMEOUT);
        end
    endtask

    // one full four-phase transaction
    task automatic run_test(input int idx, output logic ok);
        test_row_t  row;
        conv_resp_t held;
        int         errors_before;
        row           = tests[idx];
        errors_before = errors;
        req_data_i.op     = conv_op_e'(row.op);
        req_data_i.window = row.window;
        req_data_i.kernel = row.kernel;
        req_data_i.bias   = row.bias;
        req_i             = 1'b1;
        wait_ack_rise(idx, ok);
        if (ok) begin
            check_resp(resp_o, row.expected, $sformatf("test %0d response", idx));
            held = resp_o;
            // requester keeps req up a few extra cycles
            repeat (row.hold) begin
                @(posedge clk_i);
                #1;
                check_ack_high(ack_o, $sformatf("test %0d hold", idx));
                check_resp(resp_o, held, $sformatf("test %0d response during hold", idx));
            end
            req_i      = 1'b0;
            req_data_i = '0;
            // ack drops on the first edge that sees req low
            @(posedge clk_i);
            #1;
            check_ack_low(ack_o, $sformatf("test %0d release", idx));
            if (ack_o !== 1'b0) begin
                wait_ack_fall(idx, ok);
            end
        end
        if (ok && errors == errors_before) begin
            $display("test %0d op %0d: ok, data %0d err %b",
                     idx, row.op, row.expected.data, row.expected.err);
        end else begin
            tests_failed++;
            $display("test %0d op %0d: mismatch, %0d failed checks",
                     idx, row.op, errors - errors_before);
        end
    endtask

    // ====================================================================
    // main sequence
    // ====================================================================

    initial begin
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        req_i        = 1'b0;
        req_data_i   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;
        test_ok      = 1'b1;
        rng_state    = 32'd80774;
        build_table();
        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        check_ack_low(ack_o, "after reset");
        check_resp(resp_o, '0, "after reset");
        for (int i = 0; i < NUM_TESTS && !hung; i++) begin
            run_test(i, test_ok);
            tests_run++;
            if (!test_ok) begin
                hung = 1'b1;
            end
        end
        $display("tests run %0d of %0d, tests failed %0d, failed checks %0d",
                 tests_run, NUM_TESTS, tests_failed, errors);
        if (hung || errors != 0 || tests_failed != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule
